//--- logic/rx_stream_pkg.sv
package rx_stream_pkg;

   // Shared time counter and one complex sample (16-bit I, 16-bit Q)
   typedef logic [63:0] vtime_t;
   typedef logic [31:0] sample_t;

   // Status bits carried with every output entry
   typedef struct packed
   {
      logic zero_len;
      logic overrun;
      logic broken_chain;
      logic late_cmd;
      logic cmd_done;
   } rx_flags_t;

   // One output queue entry, flags in the top bits
   typedef struct packed
   {
      rx_flags_t flags;
      vtime_t    timestamp;
      sample_t   sample;
   } rx_entry_t;

   localparam int unsigned ENTRY_WIDTH = $bits(rx_entry_t);

   // Both short queues hold 2**FIFO_DEPTH_LOG2 words
   localparam int unsigned FIFO_DEPTH_LOG2 = 4;

   // Control FSM states; code 3 is unused
   typedef enum logic [2:0]
   {
      IDLE         = 3'd0,
      WAITING      = 3'd1,
      RUNNING      = 3'd2,
      OVERRUN      = 3'd4,
      BROKEN_CHAIN = 3'd5,
      LATE_CMD     = 3'd6,
      ZERO_LEN     = 3'd7
   } rx_state_e;

endpackage

//--- logic/rx_cfg_pkg.sv
package rx_cfg_pkg;

   // Settings bus
   typedef logic [7:0]  addr_t;
   typedef logic [31:0] data_t;

   // Where the three command registers sit on the settings bus
   localparam addr_t BASE_ADDR    = 8'd0;
   localparam addr_t ADDR_CMD     = BASE_ADDR + 8'd0;
   localparam addr_t ADDR_TIME_HI = BASE_ADDR + 8'd1;
   localparam addr_t ADDR_TIME_LO = BASE_ADDR + 8'd2;

   typedef logic [27:0] num_lines_t;

   // Command word in the upper 32 bits, trigger time below it
   typedef struct packed
   {
      logic                 send_imm;
      logic                 chain;
      logic                 reload;
      logic                 stop;
      num_lines_t           num_lines;
      rx_stream_pkg::vtime_t trigger_time;
   } rx_cmd_t;

   localparam int unsigned CMD_FIFO_WIDTH = $bits(rx_cmd_t);

endpackage

//--- logic/rx_settings_regs.sv
`timescale 1ns/1ps

module rx_settings_regs
(
   input  logic                clk,
   input  logic                rst_i,
   input  logic                set_stb_i,
   input  rx_cfg_pkg::addr_t   set_addr_i,
   input  rx_cfg_pkg::data_t   set_data_i,
   output rx_cfg_pkg::rx_cmd_t cmd_o,
   output logic                cmd_push_o
);

   rx_cfg_pkg::data_t cmd_word_q;
   rx_cfg_pkg::data_t time_hi_q;
   rx_cfg_pkg::data_t time_lo_q;
   logic              cmd_wr;
   logic              time_hi_wr;
   logic              time_lo_wr;

   // Address decode
   assign cmd_wr     = set_stb_i && (set_addr_i == rx_cfg_pkg::ADDR_CMD);
   assign time_hi_wr = set_stb_i && (set_addr_i == rx_cfg_pkg::ADDR_TIME_HI);
   assign time_lo_wr = set_stb_i && (set_addr_i == rx_cfg_pkg::ADDR_TIME_LO);

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         cmd_word_q <= '0;
         time_hi_q  <= '0;
         time_lo_q  <= '0;
         cmd_push_o <= 1'b0;
      end
      else
      begin
         if (cmd_wr)
         begin
            cmd_word_q <= set_data_i;
         end
         if (time_hi_wr)
         begin
            time_hi_q <= set_data_i;
         end
         if (time_lo_wr)
         begin
            time_lo_q <= set_data_i;
         end
         // Every low-time strobe queues a command, even with unchanged data
         cmd_push_o <= time_lo_wr;
      end
   end

   // Registers are already updated when the push pulse is seen
   assign cmd_o = {cmd_word_q, time_hi_q, time_lo_q};

endmodule

//--- logic/rx_short_fifo.sv
`timescale 1ns/1ps

module rx_short_fifo
#(
   parameter int unsigned WIDTH = 32
)
(
   input  logic                                      clk,
   input  logic                                      rst_i,
   input  logic                                      clear_i,
   input  logic [WIDTH-1:0]                          data_i,
   input  logic                                      push_i,
   output logic                                      full_o,
   output logic [WIDTH-1:0]                          data_o,
   output logic                                      valid_o,
   input  logic                                      pop_i,
   output logic [rx_stream_pkg::FIFO_DEPTH_LOG2:0]   count_o
);

   localparam int unsigned AW = rx_stream_pkg::FIFO_DEPTH_LOG2;
   localparam logic [AW:0] DEPTH = 1 << AW;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [AW-1:0]    wr_ptr_q;
   logic [AW-1:0]    rd_ptr_q;
   logic [AW:0]      count_q;
   logic             push_ok;
   logic             pop_ok;

   // A push into a full queue is dropped, a pop from an empty one ignored
   assign push_ok = push_i && !full_o;
   assign pop_ok  = pop_i && valid_o;

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_ok)
         begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_ok)
         begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_ok, pop_ok})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   // Head word always visible
   assign data_o  = mem[rd_ptr_q];
   assign valid_o = (count_q != '0);
   assign full_o  = (count_q == DEPTH);
   assign count_o = count_q;

endmodule

//--- logic/rx_stream_ctrl.sv
`timescale 1ns/1ps

module rx_stream_ctrl
(
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    clear_i,
   input  rx_stream_pkg::vtime_t   vita_time_i,
   input  rx_stream_pkg::sample_t  sample_i,
   input  logic                    strobe_i,
   input  rx_cfg_pkg::rx_cmd_t     cmd_i,
   input  logic                    cmd_valid_i,
   output logic                    cmd_pop_o,
   output rx_stream_pkg::rx_entry_t entry_o,
   output logic                    entry_wr_o,
   input  logic                    entry_full_i,
   output logic                    run_o,
   output logic                    overrun_o
);

   rx_stream_pkg::rx_state_e   state_q;
   rx_cfg_pkg::rx_cmd_t        active_q;
   rx_cfg_pkg::num_lines_t     lines_left_q;
   rx_cfg_pkg::num_lines_t     lines_total_q;
   rx_stream_pkg::rx_flags_t   flags;
   logic                       running;
   logic                       err_state;
   logic                       time_now;
   logic                       time_late;
   logic                       go_now;
   logic                       too_late;
   logic                       last_line;
   logic                       line_taken;
   logic                       want_write;

   assign running   = (state_q == rx_stream_pkg::RUNNING);
   assign err_state = (state_q == rx_stream_pkg::OVERRUN)
                   || (state_q == rx_stream_pkg::BROKEN_CHAIN)
                   || (state_q == rx_stream_pkg::LATE_CMD)
                   || (state_q == rx_stream_pkg::ZERO_LEN);

   // Time comparison against the active trigger
   assign time_now  = (vita_time_i == active_q.trigger_time);
   assign time_late = (vita_time_i > active_q.trigger_time);
   assign go_now    = time_now || active_q.send_imm;
   assign too_late  = time_late && !active_q.send_imm;

   assign last_line  = (lines_left_q == rx_cfg_pkg::num_lines_t'(1));
   assign line_taken = running && strobe_i && !entry_full_i;

   // Take a new command from IDLE, or the follow-up at the end of a chain
   assign cmd_pop_o = cmd_valid_i
                   && ((state_q == rx_stream_pkg::IDLE)
                   || (line_taken && last_line && active_q.chain));

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         state_q       <= rx_stream_pkg::IDLE;
         active_q      <= '0;
         lines_left_q  <= '0;
         lines_total_q <= '0;
      end
      else
      begin
         case (state_q)
            rx_stream_pkg::IDLE:
            begin
               if (cmd_valid_i)
               begin
                  active_q      <= cmd_i;
                  lines_left_q  <= cmd_i.num_lines;
                  lines_total_q <= cmd_i.num_lines;
                  if (cmd_i.stop)
                  begin
                     state_q <= rx_stream_pkg::ZERO_LEN;
                  end
                  else
                  begin
                     state_q <= rx_stream_pkg::WAITING;
                  end
               end
            end
            rx_stream_pkg::WAITING:
            begin
               if (go_now)
               begin
                  state_q <= rx_stream_pkg::RUNNING;
               end
               else if (too_late)
               begin
                  state_q <= rx_stream_pkg::LATE_CMD;
               end
            end
            rx_stream_pkg::RUNNING:
            begin
               if (strobe_i && entry_full_i)
               begin
                  state_q <= rx_stream_pkg::OVERRUN;
               end
               else if (strobe_i)
               begin
                  lines_left_q <= lines_left_q - 1'b1;
                  if (last_line)
                  begin
                     if (!active_q.chain)
                     begin
                        state_q <= rx_stream_pkg::IDLE;
                     end
                     else if (!cmd_valid_i && active_q.reload)
                     begin
                        // Nothing queued, so run the same length again
                        lines_left_q <= lines_total_q;
                     end
                     else if (!cmd_valid_i)
                     begin
                        state_q <= rx_stream_pkg::BROKEN_CHAIN;
                     end
                     else
                     begin
                        // Continue with the follow-up, its trigger is ignored
                        active_q      <= cmd_i;
                        lines_left_q  <= cmd_i.num_lines;
                        lines_total_q <= cmd_i.num_lines;
                        if (cmd_i.stop)
                        begin
                           state_q <= rx_stream_pkg::IDLE;
                        end
                     end
                  end
               end
            end
            rx_stream_pkg::OVERRUN,
            rx_stream_pkg::BROKEN_CHAIN,
            rx_stream_pkg::LATE_CMD,
            rx_stream_pkg::ZERO_LEN:
            begin
               // The flag entry goes out on the first cycle with space
               if (!entry_full_i)
               begin
                  state_q <= rx_stream_pkg::IDLE;
               end
            end
            default:
            begin
               state_q <= rx_stream_pkg::IDLE;
            end
         endcase
      end
   end

   // Entry flags
   always_comb
   begin
      flags              = '0;
      flags.zero_len     = (state_q == rx_stream_pkg::ZERO_LEN);
      flags.overrun      = (state_q == rx_stream_pkg::OVERRUN);
      flags.broken_chain = (state_q == rx_stream_pkg::BROKEN_CHAIN);
      flags.late_cmd     = (state_q == rx_stream_pkg::LATE_CMD);
      // Last line, unless a follow-up without stop keeps the stream going
      flags.cmd_done     = running && last_line
                        && (!active_q.chain || (cmd_valid_i && cmd_i.stop));
   end

   always_comb
   begin
      entry_o.flags     = flags;
      entry_o.timestamp = vita_time_i;
      entry_o.sample    = running ? sample_i : '0;
   end

   assign want_write = (running && strobe_i) || err_state;
   assign entry_wr_o = want_write && !entry_full_i;

   assign run_o     = running;
   assign overrun_o = (state_q == rx_stream_pkg::OVERRUN);

endmodule

//--- logic/rx_stream_top.sv
`timescale 1ns/1ps

module rx_stream_top
(
   input  logic                     clk,
   input  logic                     rst_i,
   input  logic                     clear_i,
   input  logic                     set_stb_i,
   input  rx_cfg_pkg::addr_t        set_addr_i,
   input  rx_cfg_pkg::data_t        set_data_i,
   input  rx_stream_pkg::vtime_t    vita_time_i,
   input  rx_stream_pkg::sample_t   sample_i,
   input  logic                     strobe_i,
   output logic                     run_o,
   output logic                     overrun_o,
   output rx_stream_pkg::rx_entry_t out_entry_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i
);

   rx_cfg_pkg::rx_cmd_t      new_cmd;
   logic                     cmd_push;
   rx_cfg_pkg::rx_cmd_t      head_cmd;
   logic                     cmd_valid;
   logic                     cmd_pop;
   rx_stream_pkg::rx_entry_t entry;
   logic                     entry_wr;
   logic                     entry_full;

   rx_settings_regs settings_regs
   (
      .clk        (clk),
      .rst_i      (rst_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .cmd_o      (new_cmd),
      .cmd_push_o (cmd_push)
   );

   // Queued commands from the host
   rx_short_fifo #(.WIDTH(rx_cfg_pkg::CMD_FIFO_WIDTH)) cmd_fifo
   (
      .clk     (clk),
      .rst_i   (rst_i),
      .clear_i (clear_i),
      .data_i  (new_cmd),
      .push_i  (cmd_push),
      .full_o  (),
      .data_o  (head_cmd),
      .valid_o (cmd_valid),
      .pop_i   (cmd_pop),
      .count_o ()
   );

   rx_stream_ctrl ctrl
   (
      .clk          (clk),
      .rst_i        (rst_i),
      .clear_i      (clear_i),
      .vita_time_i  (vita_time_i),
      .sample_i     (sample_i),
      .strobe_i     (strobe_i),
      .cmd_i        (head_cmd),
      .cmd_valid_i  (cmd_valid),
      .cmd_pop_o    (cmd_pop),
      .entry_o      (entry),
      .entry_wr_o   (entry_wr),
      .entry_full_i (entry_full),
      .run_o        (run_o),
      .overrun_o    (overrun_o)
   );

   // Samples and status entries toward the framer
   rx_short_fifo #(.WIDTH(rx_stream_pkg::ENTRY_WIDTH)) entry_fifo
   (
      .clk     (clk),
      .rst_i   (rst_i),
      .clear_i (clear_i),
      .data_i  (entry),
      .push_i  (entry_wr),
      .full_o  (entry_full),
      .data_o  (out_entry_o),
      .valid_o (out_valid_o),
      .pop_i   (out_ready_i),
      .count_o ()
   );

endmodule

//--- testbench/rx_stream_assertions.sv
`timescale 1ns/1ps

module rx_stream_assertions
(
   input logic                     clk,
   input logic                     rst_i,
   input logic                     clear_i,
   input logic                     run_o,
   input logic                     entry_wr_o,
   input logic                     entry_full_i,
   input logic                     cmd_pop_o,
   input logic                     cmd_valid_i,
   input logic                     err_state,
   input rx_stream_pkg::rx_state_e state_q
);

   // run_o follows the RUNNING state only
   assert property (@(posedge clk) disable iff (rst_i)
      run_o |-> (state_q == rx_stream_pkg::RUNNING))
      else $error("run_o high outside RUNNING");

   assert property (@(posedge clk) disable iff (rst_i)
      entry_wr_o |-> !entry_full_i)
      else $error("entry write into a full output queue");

   assert property (@(posedge clk) disable iff (rst_i)
      cmd_pop_o |-> cmd_valid_i)
      else $error("command pop with an empty command queue");

   // One flag entry, then back to IDLE
   assert property (@(posedge clk) disable iff (rst_i || clear_i)
      (err_state && !entry_full_i) |=> (state_q == rx_stream_pkg::IDLE))
      else $error("error state held after space appeared");

endmodule

bind rx_stream_ctrl rx_stream_assertions ctrl_checks
(
   .clk          (clk),
   .rst_i        (rst_i),
   .clear_i      (clear_i),
   .run_o        (run_o),
   .entry_wr_o   (entry_wr_o),
   .entry_full_i (entry_full_i),
   .cmd_pop_o    (cmd_pop_o),
   .cmd_valid_i  (cmd_valid_i),
   .err_state    (err_state),
   .state_q      (state_q)
);

//--- testbench/rx_stream_tb.sv
`timescale 1ns/1ps

module rx_stream_tb;

   typedef struct packed
   {
      logic               send_imm;
      logic               chain;
      logic               reload;
      logic               stop;
      logic [7:0]         lines;
      logic signed [15:0] trig_off;
      logic [7:0]         gap;
      logic               link;
      logic               backpress;
      logic               clear_mid;
      logic               half_rate;
   } row_t;

   localparam int NUM_ROWS = 12;

   // imm chain reload stop lines trig_off gap link backpress clear_mid half_rate
   localparam row_t ROWS [NUM_ROWS] = '{
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd6,  16'sd0,  8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd5,  16'sd20, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b0, 8'd4,  -16'sd5, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b0, 1'b0, 1'b0, 1'b1, 8'd0,  16'sd0,  8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b1, 1'b0, 1'b0, 8'd5,  16'sd0,  8'd0, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd3,  16'sd0,  8'd0, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b1, 1'b0, 1'b0, 8'd3,  16'sd0,  8'd0, 1'b0, 1'b0, 1'b0, 1'b1},
      '{1'b1, 1'b1, 1'b1, 1'b0, 8'd4,  16'sd0,  8'd0, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b0, 1'b1, 8'd0,  16'sd0,  8'd6, 1'b0, 1'b0, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd40, 16'sd0,  8'd0, 1'b0, 1'b1, 1'b0, 1'b0},
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd30, 16'sd0,  8'd0, 1'b0, 1'b0, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b0, 1'b0, 8'd4,  16'sd0,  8'd0, 1'b0, 1'b0, 1'b0, 1'b0}
   };

   logic                     clk;
   logic                     rst_i;
   logic                     clear_i;
   logic                     set_stb_i;
   rx_cfg_pkg::addr_t        set_addr_i;
   rx_cfg_pkg::data_t        set_data_i;
   rx_stream_pkg::vtime_t    vita_time_i;
   rx_stream_pkg::sample_t   sample_i;
   logic                     strobe_i;
   logic                     run_o;
   logic                     overrun_o;
   rx_stream_pkg::rx_entry_t out_entry_o;
   logic                     out_valid_o;
   logic                     out_ready_i;

   integer                   seed;
   bit                       strobe_half;
   rx_stream_pkg::sample_t   sample_mem [256];
   rx_stream_pkg::rx_entry_t got_q [$];
   rx_stream_pkg::rx_entry_t exp_q [$];
   bit                       exp_skip_ts [$];
   row_t                     grp_row [$];
   rx_stream_pkg::vtime_t    grp_v0 [$];
   rx_stream_pkg::vtime_t    grp_trig [$];

   rx_stream_top UUT
   (
      .clk         (clk),
      .rst_i       (rst_i),
      .clear_i     (clear_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_i (vita_time_i),
      .sample_i    (sample_i),
      .strobe_i    (strobe_i),
      .run_o       (run_o),
      .overrun_o   (overrun_o),
      .out_entry_o (out_entry_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always #4 clk = ~clk;

   // Time counter and sample source, sample picked by the low time bits
   always @(posedge clk)
   begin
      #1;
      vita_time_i = vita_time_i + 64'd1;
      sample_i    = sample_mem[vita_time_i[7:0]];
      // At half rate only even time stamps carry a strobe
      strobe_i    = !strobe_half || !vita_time_i[0];
   end

   // Capture every transfer on the output side
   always @(negedge clk)
   begin
      if (!rst_i && out_valid_o && out_ready_i)
      begin
         got_q.push_back(out_entry_o);
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_entry(input rx_stream_pkg::rx_entry_t got,
                              input rx_stream_pkg::rx_entry_t exp, input string what);
      if (got !== exp)
      begin
         abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_flags(input rx_stream_pkg::rx_flags_t got,
                              input rx_stream_pkg::rx_flags_t exp, input string what);
      if (got !== exp)
      begin
         abort_run($sformatf("mismatch at %0t: %s flags %b expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         abort_run($sformatf("mismatch at %0t: %s is %b expected %b", $time, what, got, exp));
      end
   endtask

   function automatic longint watchdog_cycles();
      longint total;
      total = 200;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         total += ROWS[r].gap + 3 * ROWS[r].lines + 80;
         total += (ROWS[r].trig_off < 0) ? -ROWS[r].trig_off : ROWS[r].trig_off;
      end
      return total;
   endfunction

   initial
   begin
      #(watchdog_cycles() * 8);
      abort_run("timeout: the run hung waiting for output entries");
   end

   // Three settings writes; returns the time of the low-word cycle and the trigger
   task automatic write_cmd(input row_t row, output rx_stream_pkg::vtime_t v0,
                            output rx_stream_pkg::vtime_t trig);
      rx_cfg_pkg::rx_cmd_t cmd;
      @(posedge clk);
      v0 = vita_time_i + 64'd3;
      trig = rx_stream_pkg::vtime_t'(longint'(v0) + longint'(row.trig_off));
      cmd.send_imm     = row.send_imm;
      cmd.chain        = row.chain;
      cmd.reload       = row.reload;
      cmd.stop         = row.stop;
      cmd.num_lines    = rx_cfg_pkg::num_lines_t'(row.lines);
      cmd.trigger_time = trig;
      #1;
      set_stb_i  = 1'b1;
      set_addr_i = rx_cfg_pkg::ADDR_CMD;
      set_data_i = cmd[95:64];
      @(posedge clk);
      #1;
      set_addr_i = rx_cfg_pkg::ADDR_TIME_HI;
      set_data_i = cmd[63:32];
      @(posedge clk);
      #1;
      set_addr_i = rx_cfg_pkg::ADDR_TIME_LO;
      set_data_i = cmd[31:0];
      @(posedge clk);
      #1;
      set_stb_i = 1'b0;
   endtask

   task automatic add_entry(input rx_stream_pkg::rx_flags_t f, input rx_stream_pkg::vtime_t t,
                            input bit with_sample, input bit skip_ts);
      rx_stream_pkg::rx_entry_t e;
      e.flags     = f;
      e.timestamp = t;
      e.sample    = with_sample ? sample_mem[t[7:0]] : '0;
      exp_q.push_back(e);
      exp_skip_ts.push_back(skip_ts);
   endtask

   // First time stamp at or after t that sees a strobe
   function automatic rx_stream_pkg::vtime_t strobe_time(input rx_stream_pkg::vtime_t t,
                                                          input bit half_rate);
      if (half_rate && t[0])
      begin
         return t + 64'd1;
      end
      return t;
   endfunction

   // Reference model of one command group, derived from the controller timing rules
   task automatic build_expected();
      rx_stream_pkg::rx_flags_t f;
      rx_stream_pkg::vtime_t    t;
      int                       cur;
      int                       nxt;
      bit                       done;
      bit                       vis;
      exp_q.delete();
      exp_skip_ts.delete();
      f = '0;
      if (grp_row[0].stop)
      begin
         f.zero_len = 1'b1;
         add_entry(f, grp_v0[0] + 64'd3, 1'b0, 1'b0);
         return;
      end
      if (!grp_row[0].send_imm && (grp_trig[0] < grp_v0[0] + 64'd3))
      begin
         f.late_cmd = 1'b1;
         add_entry(f, grp_v0[0] + 64'd4, 1'b0, 1'b0);
         return;
      end
      t = grp_row[0].send_imm ? grp_v0[0] + 64'd4 : grp_trig[0] + 64'd1;
      if (grp_row[0].backpress)
      begin
         for (int j = 0; j < 16; j++)
         begin
            add_entry(f, t + 64'(j), 1'b1, 1'b0);
         end
         f.overrun = 1'b1;
         add_entry(f, '0, 1'b0, 1'b1);
         return;
      end
      cur  = 0;
      done = 1'b0;
      while (!done)
      begin
         for (int j = 0; j < grp_row[cur].lines && !done; j++)
         begin
            t = strobe_time(t, grp_row[0].half_rate);
            f = '0;
            if (j < grp_row[cur].lines - 1)
            begin
               add_entry(f, t, 1'b1, 1'b0);
            end
            else
            begin
               nxt = cur + 1;
               vis = (nxt < grp_row.size()) && (grp_v0[nxt] + 64'd2 <= t);
               if (!grp_row[cur].chain || (vis && grp_row[nxt].stop))
               begin
                  f.cmd_done = 1'b1;
                  add_entry(f, t, 1'b1, 1'b0);
                  done = 1'b1;
               end
               else if (vis)
               begin
                  add_entry(f, t, 1'b1, 1'b0);
                  cur = nxt;
               end
               else if (grp_row[cur].reload)
               begin
                  add_entry(f, t, 1'b1, 1'b0);
               end
               else
               begin
                  add_entry(f, t, 1'b1, 1'b0);
                  f.broken_chain = 1'b1;
                  add_entry(f, t + 64'd1, 1'b0, 1'b0);
                  done = 1'b1;
               end
            end
            t = t + 64'd1;
         end
      end
   endtask

   initial
   begin
      rx_stream_pkg::vtime_t v0;
      rx_stream_pkg::vtime_t trig;
      rx_stream_pkg::vtime_t now;
      int                    i;
      clk         = 1'b0;
      rst_i       = 1'b1;
      clear_i     = 1'b0;
      set_stb_i   = 1'b0;
      set_addr_i  = '0;
      set_data_i  = '0;
      vita_time_i = '0;
      sample_i    = '0;
      strobe_i    = 1'b0;
      strobe_half = 1'b0;
      out_ready_i = 1'b1;
      seed        = 36617;
      for (int k = 0; k < 256; k++)
      begin
         sample_mem[k] = $random(seed);
      end
      repeat (5) @(posedge clk);
      #1;
      rst_i = 1'b0;
      @(negedge clk);
      check_level(out_valid_o, 1'b0, "out_valid_o after reset");
      check_level(run_o, 1'b0, "run_o after reset");
      check_level(overrun_o, 1'b0, "overrun_o after reset");

      i = 0;
      while (i < NUM_ROWS)
      begin
         grp_row.delete();
         grp_v0.delete();
         grp_trig.delete();
         got_q.delete();
         strobe_half = ROWS[i].half_rate;
         do
         begin
            repeat (ROWS[i].gap) @(posedge clk);
            if (ROWS[i].backpress)
            begin
               out_ready_i = 1'b0;
            end
            write_cmd(ROWS[i], v0, trig);
            grp_row.push_back(ROWS[i]);
            grp_v0.push_back(v0);
            grp_trig.push_back(trig);
            i++;
         end
         while (ROWS[i-1].link && i < NUM_ROWS);

         if (grp_row[0].clear_mid)
         begin
            repeat (10) @(posedge clk);
            #1;
            clear_i = 1'b1;
            @(posedge clk);
            #1;
            clear_i = 1'b0;
            @(negedge clk);
            check_level(out_valid_o, 1'b0, "out_valid_o after clear");
            check_level(run_o, 1'b0, "run_o after clear");
            check_level(overrun_o, 1'b0, "overrun_o after clear");
            got_q.delete();
            continue;
         end

         // Nothing may run before a future trigger
         if (!grp_row[0].send_imm && grp_trig[0] > grp_v0[0])
         begin
            do
            begin
               @(negedge clk);
               now = vita_time_i;
               if (now <= grp_trig[0])
               begin
                  check_level(run_o, 1'b0, "run_o before trigger");
               end
            end
            while (now < grp_trig[0]);
         end

         if (grp_row[0].backpress)
         begin
            do
            begin
               @(negedge clk);
            end
            while (vita_time_i < grp_v0[0] + 64'd24);
            check_level(overrun_o, 1'b1, "overrun_o with full queue");
            check_level(run_o, 1'b0, "run_o in overrun");
            @(posedge clk);
            #1;
            out_ready_i = 1'b1;
         end

         build_expected();
         while (got_q.size() < exp_q.size())
         begin
            @(posedge clk);
         end
         repeat (8) @(posedge clk);
         if (got_q.size() != exp_q.size())
         begin
            abort_run($sformatf("output queue gave %0d entries where %0d were due",
                                got_q.size(), exp_q.size()));
         end
         for (int k = 0; k < exp_q.size(); k++)
         begin
            if (exp_skip_ts[k])
            begin
               check_flags(got_q[k].flags, exp_q[k].flags, $sformatf("entry %0d", k));
            end
            else
            begin
               check_entry(got_q[k], exp_q[k], $sformatf("entry %0d", k));
            end
         end
         @(negedge clk);
         check_level(run_o, 1'b0, "run_o after command group");
         check_level(overrun_o, 1'b0, "overrun_o after command group");
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- files.f
logic/rx_stream_pkg.sv
logic/rx_cfg_pkg.sv
logic/rx_settings_regs.sv
logic/rx_short_fifo.sv
logic/rx_stream_ctrl.sv
logic/rx_stream_top.sv
testbench/rx_stream_assertions.sv
testbench/rx_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict from sim.log

verilator --binary --assert -Wno-fatal --top-module rx_stream_tb -f files.f > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vrx_stream_tb > sim.log 2>&1

grep -q "SIMULATION FAILED" sim.log && { echo "FAIL"; exit 1; } \
   || grep -q "SIMULATION PASSED" sim.log && { echo "PASS"; exit 0; } \
   || { echo "FAIL: no verdict in sim.log"; exit 1; }
